/* Makefile */
TOP = tb_conv_layer_top

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f conv_layer.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* conv_layer.f */
verilog/conv_pkg.sv
verilog/coef_store.sv
verilog/image_ram.sv
verilog/window_buffer.sv
verilog/conv_sequencer.sv
verilog/conv_engine.sv
verilog/conv_layer_top.sv
tb/tb_conv_layer_top.sv

/* tb/tb_conv_layer_top.sv */
`timescale 1ns/1ps

module tb_conv_layer_top;

  localparam int frame_results = conv_pkg::out_size * conv_pkg::out_size;
  localparam int frame_timeout = 4000;

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic                 coef_wr;
  conv_pkg::coef_addr_t coef_addr;
  conv_pkg::pixel_t     coef_data;
  logic                 img_wr;
  conv_pkg::img_addr_t  img_addr;
  conv_pkg::pixel_t     img_data;
  logic                 busy;
  logic                 done;
  logic                 out_valid;
  conv_pkg::line_idx_t  out_row;
  conv_pkg::line_idx_t  out_col;
  conv_pkg::pixel_t     out_data [conv_pkg::num_channels];

  // host copies of everything written
  conv_pkg::pixel_t img_mem  [conv_pkg::img_size][conv_pkg::img_size];
  conv_pkg::pixel_t coef_mem [conv_pkg::num_coefs];
  conv_pkg::pixel_t exp_out  [conv_pkg::num_channels][conv_pkg::out_size][conv_pkg::out_size];

  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          test_errors;
  int          sat_count;

  conv_layer_top i_conv_layer_top (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .coef_wr   (coef_wr),
    .coef_addr (coef_addr),
    .coef_data (coef_data),
    .img_wr    (img_wr),
    .img_addr  (img_addr),
    .img_data  (img_data),
    .busy      (busy),
    .done      (done),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_col   (out_col),
    .out_data  (out_data)
  );

  always #4 clk = ~clk;

  // inputs change 1 ns after the edge where outputs are stable
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // magnitude under 64
  function automatic conv_pkg::pixel_t small_rand();
    int v;
    v = int'(next_rand() >> 16) % 127 - 63;
    return conv_pkg::pixel_t'(v);
  endfunction

  function automatic conv_pkg::pixel_t full_rand();
    logic [31:0] r;
    r = next_rand();
    return conv_pkg::pixel_t'(r[27:16]);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  task automatic load_coefs(input bit full_range);
    for (int a = 0; a < conv_pkg::num_coefs; a++) begin
      coef_mem[a] = full_range ? full_rand() : small_rand();
      coef_wr     = 1'b1;
      coef_addr   = conv_pkg::coef_addr_t'(a);
      coef_data   = coef_mem[a];
      tick();
    end
    coef_wr = 1'b0;
  endtask

  task automatic load_image();
    for (int c = 0; c < conv_pkg::img_size; c++) begin
      for (int r = 0; r < conv_pkg::img_size; r++) begin
        img_mem[c][r] = full_rand();
        img_wr        = 1'b1;
        img_addr      = conv_pkg::img_addr_t'(c * conv_pkg::img_size + r);
        img_data      = img_mem[c][r];
        tick();
      end
    end
    img_wr = 1'b0;
  endtask

  // sum of 25 products plus bias << 8 shifted back and saturated
  task automatic compute_expected();
    longint acc;
    longint scaled;
    int     base;
    sat_count = 0;
    for (int ch = 0; ch < conv_pkg::num_channels; ch++) begin
      base = ch * conv_pkg::coef_per_channel;
      for (int c = 0; c < conv_pkg::out_size; c++) begin
        for (int r = 0; r < conv_pkg::out_size; r++) begin
          acc = longint'(coef_mem[base + 25]) * (longint'(1) << conv_pkg::frac_bits);
          for (int dc = 0; dc < 5; dc++) begin
            for (int dr = 0; dr < 5; dr++) begin
              acc += longint'(coef_mem[base + dc * 5 + dr]) * longint'(img_mem[c + dc][r + dr]);
            end
          end
          scaled = acc >>> conv_pkg::frac_bits;
          if (scaled > 2047 || scaled < -2048) begin
            sat_count++;
          end
          if (scaled > 2047) begin
            exp_out[ch][c][r] = 12'sd2047;
          end else if (scaled < -2048) begin
            exp_out[ch][c][r] = -12'sd2048;
          end else begin
            exp_out[ch][c][r] = conv_pkg::pixel_t'(scaled);
          end
        end
      end
    end
  endtask

  // one frame with an optional stray start while busy
  task automatic run_frame(input int stray_start);
    int cycles;
    int n;
    int col;
    int row;
    bit done_seen;
    cycles    = 0;
    n         = 0;
    done_seen = 1'b0;
    start     = 1'b1;
    tick();
    start = 1'b0;
    check_value("busy after start", busy, 1);
    while (!done_seen && cycles < frame_timeout) begin
      start = (cycles == stray_start);
      if (out_valid) begin
        if (n < frame_results) begin
          col = n / conv_pkg::out_size;
          row = n % conv_pkg::out_size;
          check_value($sformatf("out_col at result %0d", n), out_col, col);
          check_value($sformatf("out_row at result %0d", n), out_row, row);
          for (int ch = 0; ch < conv_pkg::num_channels; ch++) begin
            check_value($sformatf("out_data[%0d] at col %0d row %0d", ch, col, row),
                        out_data[ch], exp_out[ch][col][row]);
          end
        end else begin
          report_error("more out_valid cycles than output pixels");
        end
        n++;
      end
      if (done) begin
        done_seen = 1'b1;
        check_value("result count at done", n, frame_results);
        check_value("busy at done", busy, 0);
        check_value("out_valid at done", out_valid, 0);
      end
      tick();
      cycles++;
    end
    start = 1'b0;
    if (!done_seen) begin
      report_error("timed out waiting for done");
    end
  endtask

  task automatic check_quiet(input int n_cycles);
    for (int i = 0; i < n_cycles; i++) begin
      check_value("busy", busy, 0);
      check_value("done", done, 0);
      check_value("out_valid", out_valid, 0);
      tick();
    end
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    start     = 1'b0;
    coef_wr   = 1'b0;
    coef_addr = '0;
    coef_data = '0;
    img_wr    = 1'b0;
    img_addr  = '0;
    img_data  = '0;
    lcg_state = 32'd91764;
    errors    = 0;
    checks    = 0;
    repeat (5) tick();
    reset = 1'b0;

    test_errors = errors;
    check_quiet(10);
    $display("test 1 idle after reset: %0d errors", errors - test_errors);

    test_errors = errors;
    load_coefs(1'b0);
    load_image();
    compute_expected();
    run_frame(-1);
    $display("test 2 small coefficient frame: %0d errors", errors - test_errors);

    // exactly one done and nothing trails it
    test_errors = errors;
    check_quiet(20);
    $display("test 3 quiet after done: %0d errors", errors - test_errors);

    test_errors = errors;
    load_coefs(1'b1);
    load_image();
    compute_expected();
    if (sat_count == 0) begin
      report_error("full-range data produced no saturated results");
    end
    if (sat_count == conv_pkg::num_channels * frame_results) begin
      report_error("full-range data produced no in-range results");
    end
    run_frame(-1);
    check_quiet(5);
    $display("test 4 full range frame, %0d saturated, %0d in range: %0d errors",
             sat_count, conv_pkg::num_channels * frame_results - sat_count,
             errors - test_errors);

    test_errors = errors;
    run_frame(300);
    check_quiet(5);
    load_coefs(1'b0);
    compute_expected();
    run_frame(-1);
    check_quiet(5);
    $display("test 5 stray start and second frame: %0d errors", errors - test_errors);

    $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* verilog/coef_store.sv */
`timescale 1ns/1ps

module coef_store (
  input  logic                 clk,
  input  logic                 coef_wr,
  input  conv_pkg::coef_addr_t coef_addr,
  input  conv_pkg::pixel_t     coef_data,
  output conv_pkg::pixel_t     weights [conv_pkg::num_channels][conv_pkg::kern_taps],
  output conv_pkg::pixel_t     biases  [conv_pkg::num_channels]
);

  // flat register file, channel * 26 + index
  conv_pkg::pixel_t coef [conv_pkg::num_coefs];

  always_ff @(posedge clk) begin
    // addresses past the last bias are dropped
    if (coef_wr && (coef_addr < conv_pkg::num_coefs)) begin
      coef[coef_addr] <= coef_data;
    end
  end

  // every register goes out in parallel
  genvar ch;
  genvar tap;
  generate
    for (ch = 0; ch < conv_pkg::num_channels; ch++) begin : g_channel
      for (tap = 0; tap < conv_pkg::kern_taps; tap++) begin : g_tap
        assign weights[ch][tap] = coef[ch * conv_pkg::coef_per_channel + tap];
      end
      // bias sits right after the 25 weights
      assign biases[ch] = coef[ch * conv_pkg::coef_per_channel + conv_pkg::kern_taps];
    end
  endgenerate

endmodule

/* verilog/conv_engine.sv */
`timescale 1ns/1ps

module conv_engine (
  input  logic                clk,
  input  logic                reset,
  input  logic                calc,
  input  conv_pkg::line_idx_t cur_row,
  input  conv_pkg::pixel_t    window  [conv_pkg::kern_size][conv_pkg::img_size],
  input  conv_pkg::pixel_t    weights [conv_pkg::num_channels][conv_pkg::kern_taps],
  input  conv_pkg::pixel_t    biases  [conv_pkg::num_channels],
  output logic                out_valid,
  output conv_pkg::pixel_t    out_data [conv_pkg::num_channels]
);

  conv_pkg::acc_t   acc    [conv_pkg::num_channels];
  conv_pkg::acc_t   scaled [conv_pkg::num_channels];
  conv_pkg::pixel_t result [conv_pkg::num_channels];

  // full-precision sum, then back to q4.8 with saturation
  always_comb begin
    for (int ch = 0; ch < conv_pkg::num_channels; ch++) begin
      acc[ch] = conv_pkg::acc_t'(biases[ch]) <<< conv_pkg::frac_bits;
      for (int dc = 0; dc < conv_pkg::kern_size; dc++) begin
        for (int dr = 0; dr < conv_pkg::kern_size; dr++) begin
          // weight index is column offset * 5 + row offset
          acc[ch] = acc[ch] +
                    conv_pkg::acc_t'(weights[ch][dc * conv_pkg::kern_size + dr]) *
                    conv_pkg::acc_t'(window[dc][conv_pkg::line_idx_t'(cur_row + dr)]);
        end
      end
      scaled[ch] = acc[ch] >>> conv_pkg::frac_bits;
      if (scaled[ch] > conv_pkg::pixel_max) begin
        result[ch] = conv_pkg::pixel_t'(conv_pkg::pixel_max);
      end else if (scaled[ch] < conv_pkg::pixel_min) begin
        result[ch] = conv_pkg::pixel_t'(conv_pkg::pixel_min);
      end else begin
        result[ch] = conv_pkg::pixel_t'(scaled[ch]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= calc;
    end
  end

  // result data only moves with a calc
  always_ff @(posedge clk) begin
    if (calc) begin
      for (int ch = 0; ch < conv_pkg::num_channels; ch++) begin
        out_data[ch] <= result[ch];
      end
    end
  end

endmodule

/* verilog/conv_layer_top.sv */
`timescale 1ns/1ps

module conv_layer_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 coef_wr,
  input  conv_pkg::coef_addr_t coef_addr,
  input  conv_pkg::pixel_t     coef_data,
  input  logic                 img_wr,
  input  conv_pkg::img_addr_t  img_addr,
  input  conv_pkg::pixel_t     img_data,
  output logic                 busy,
  output logic                 done,
  output logic                 out_valid,
  output conv_pkg::line_idx_t  out_row,
  output conv_pkg::line_idx_t  out_col,
  output conv_pkg::pixel_t     out_data [conv_pkg::num_channels]
);

  // column read path
  logic                line_rd;
  conv_pkg::line_idx_t line_addr;
  conv_pkg::pixel_t    line_data [conv_pkg::img_size];

  // window control
  logic                load_col;
  logic [2:0]          fill_slot;
  logic                shift;
  conv_pkg::pixel_t    window [conv_pkg::kern_size][conv_pkg::img_size];

  // engine control and coefficients
  logic                calc;
  conv_pkg::line_idx_t cur_row;
  conv_pkg::pixel_t    weights [conv_pkg::num_channels][conv_pkg::kern_taps];
  conv_pkg::pixel_t    biases  [conv_pkg::num_channels];

  coef_store i_coef_store (
    .clk       (clk),
    .coef_wr   (coef_wr),
    .coef_addr (coef_addr),
    .coef_data (coef_data),
    .weights   (weights),
    .biases    (biases)
  );

  image_ram i_image_ram (
    .clk       (clk),
    .img_wr    (img_wr),
    .img_addr  (img_addr),
    .img_data  (img_data),
    .line_rd   (line_rd),
    .line_addr (line_addr),
    .line_data (line_data)
  );

  window_buffer i_window_buffer (
    .clk       (clk),
    .reset     (reset),
    .load_col  (load_col),
    .fill_slot (fill_slot),
    .shift     (shift),
    .line_data (line_data),
    .window    (window)
  );

  conv_sequencer i_conv_sequencer (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .line_rd   (line_rd),
    .line_addr (line_addr),
    .load_col  (load_col),
    .fill_slot (fill_slot),
    .shift     (shift),
    .calc      (calc),
    .cur_row   (cur_row),
    .out_row   (out_row),
    .out_col   (out_col),
    .busy      (busy),
    .done      (done)
  );

  conv_engine i_conv_engine (
    .clk       (clk),
    .reset     (reset),
    .calc      (calc),
    .cur_row   (cur_row),
    .window    (window),
    .weights   (weights),
    .biases    (biases),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* verilog/conv_pkg.sv */
package conv_pkg;

  // image and kernel geometry
  localparam int img_size         = 32;
  localparam int kern_size        = 5;
  localparam int kern_taps        = kern_size * kern_size;
  localparam int num_channels     = 6;
  localparam int out_size         = img_size - kern_size + 1;

  // coefficient layout, 25 weights then the bias
  localparam int coef_per_channel = kern_taps + 1;
  localparam int num_coefs        = num_channels * coef_per_channel;

  // q4.8 fixed point
  localparam int frac_bits        = 8;
  localparam int pixel_width      = 12;
  localparam int acc_width        = 32;
  localparam int pixel_max        = 2047;
  localparam int pixel_min        = -2048;

  typedef logic signed [pixel_width-1:0] pixel_t;
  typedef logic [7:0]                    coef_addr_t;
  // column * 32 + row
  typedef logic [9:0]                    img_addr_t;
  typedef logic [4:0]                    line_idx_t;
  typedef logic signed [acc_width-1:0]   acc_t;

  typedef enum logic [2:0] {
    st_idle,
    st_fill,
    st_compute,
    st_shift,
    st_finish
  } seq_state_t;

endpackage

/* verilog/conv_sequencer.sv */
`timescale 1ns/1ps

module conv_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  output logic                line_rd,
  output conv_pkg::line_idx_t line_addr,
  output logic                load_col,
  output logic [2:0]          fill_slot,
  output logic                shift,
  output logic                calc,
  output conv_pkg::line_idx_t cur_row,
  output conv_pkg::line_idx_t out_row,
  output conv_pkg::line_idx_t out_col,
  output logic                busy,
  output logic                done
);

  conv_pkg::seq_state_t state;
  logic [2:0]           fill_cnt;
  conv_pkg::line_idx_t  row_cnt;
  conv_pkg::line_idx_t  col_cnt;
  logic                 shift_phase;
  logic                 fill_rd;
  logic                 last_row;
  logic                 last_col;

  assign last_row = (row_cnt == conv_pkg::line_idx_t'(conv_pkg::out_size - 1));
  assign last_col = (col_cnt == conv_pkg::line_idx_t'(conv_pkg::out_size - 1));

  // reads 0..4 during fill, one more per window shift
  assign fill_rd   = (state == conv_pkg::st_fill) && (fill_cnt < conv_pkg::kern_size);
  assign line_rd   = fill_rd || ((state == conv_pkg::st_shift) && !shift_phase);
  assign line_addr = (state == conv_pkg::st_fill) ? conv_pkg::line_idx_t'(fill_cnt) :
                     conv_pkg::line_idx_t'(col_cnt + conv_pkg::kern_size);

  assign calc    = (state == conv_pkg::st_compute);
  assign cur_row = row_cnt;
  assign busy    = (state != conv_pkg::st_idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= conv_pkg::st_idle;
      fill_cnt    <= '0;
      row_cnt     <= '0;
      col_cnt     <= '0;
      shift_phase <= 1'b0;
      load_col    <= 1'b0;
      shift       <= 1'b0;
      done        <= 1'b0;
    end else begin
      // window updates trail the read by the ram latency
      load_col <= fill_rd;
      shift    <= (state == conv_pkg::st_shift) && !shift_phase;
      // one cycle after the last result leaves the engine
      done     <= (state == conv_pkg::st_finish);
      case (state)
        conv_pkg::st_idle: begin
          if (start) begin
            state    <= conv_pkg::st_fill;
            fill_cnt <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
          end
        end
        conv_pkg::st_fill: begin
          fill_cnt <= fill_cnt + 3'd1;
          // wait for the slot 4 load before computing
          if (fill_cnt == conv_pkg::kern_size) begin
            state <= conv_pkg::st_compute;
          end
        end
        conv_pkg::st_compute: begin
          if (last_row) begin
            row_cnt <= '0;
            state   <= last_col ? conv_pkg::st_finish : conv_pkg::st_shift;
          end else begin
            row_cnt <= row_cnt + 5'd1;
          end
        end
        conv_pkg::st_shift: begin
          shift_phase <= !shift_phase;
          if (shift_phase) begin
            state   <= conv_pkg::st_compute;
            col_cnt <= col_cnt + 5'd1;
          end
        end
        conv_pkg::st_finish: state <= conv_pkg::st_idle;
        default:             state <= conv_pkg::st_idle;
      endcase
    end
  end

  // slot and position labels follow their strobes
  always_ff @(posedge clk) begin
    fill_slot <= fill_cnt;
    if (calc) begin
      out_row <= row_cnt;
      out_col <= col_cnt;
    end
  end

endmodule

/* verilog/image_ram.sv */
`timescale 1ns/1ps

module image_ram (
  input  logic                 clk,
  input  logic                 img_wr,
  input  conv_pkg::img_addr_t  img_addr,
  input  conv_pkg::pixel_t     img_data,
  input  logic                 line_rd,
  input  conv_pkg::line_idx_t  line_addr,
  output conv_pkg::pixel_t     line_data [conv_pkg::img_size]
);

  // organized as [column][row]
  conv_pkg::pixel_t mem [conv_pkg::img_size][conv_pkg::img_size];

  conv_pkg::line_idx_t wr_col;
  conv_pkg::line_idx_t wr_row;

  // upper bits pick the column, lower bits the row
  assign wr_col = img_addr[9:5];
  assign wr_row = img_addr[4:0];

  always_ff @(posedge clk) begin
    if (img_wr) begin
      mem[wr_col][wr_row] <= img_data;
    end
  end

  // whole column out, one cycle after the request
  always_ff @(posedge clk) begin
    if (line_rd) begin
      line_data <= mem[line_addr];
    end
  end

endmodule

/* verilog/window_buffer.sv */
`timescale 1ns/1ps

module window_buffer (
  input  logic             clk,
  input  logic             reset,
  input  logic             load_col,
  input  logic [2:0]       fill_slot,
  input  logic             shift,
  input  conv_pkg::pixel_t line_data [conv_pkg::img_size],
  output conv_pkg::pixel_t window    [conv_pkg::kern_size][conv_pkg::img_size]
);

  // slot 0 holds the oldest column, slot 4 the newest
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < conv_pkg::kern_size; s++) begin
        for (int r = 0; r < conv_pkg::img_size; r++) begin
          window[s][r] <= '0;
        end
      end
    end else if (shift) begin
      // drop slot 0, new column enters at the top
      for (int s = 0; s < conv_pkg::kern_size - 1; s++) begin
        for (int r = 0; r < conv_pkg::img_size; r++) begin
          window[s][r] <= window[s + 1][r];
        end
      end
      for (int r = 0; r < conv_pkg::img_size; r++) begin
        window[conv_pkg::kern_size - 1][r] <= line_data[r];
      end
    end else if (load_col) begin
      // initial fill, one slot per read
      for (int r = 0; r < conv_pkg::img_size; r++) begin
        window[fill_slot][r] <= line_data[r];
      end
    end
  end

endmodule
